/* rtl/ifu_config.svh */
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// ======================================================================
// fetch unit build constants
// ======================================================================

// general register width
// also the width of every pc word
`define IFU_GRLEN 32

// boot address after reset
// one word, aligned to 4 bytes
`define IFU_PC_RESET 32'h1c00_0000

`endif

/* rtl/ifu_pkg.sv */
`include "ifu_config.svh"

package ifu_pkg;

   // one pc word
   typedef logic [`IFU_GRLEN-1:0] pc_t;

   // redirect pulses from execute
   // each valid bit is high for a single cycle
   typedef struct packed {
      logic br_taken;
      pc_t  br_target;
      logic except;
      pc_t  eentry;
      logic ertn;
      pc_t  era;
   } redirect_t;

   // toward instruction memory
   typedef struct packed {
      logic req;
      pc_t  addr;
      logic cancel;
   } fetch_req_t;

   // back from instruction memory
   // valid alone marks the end of a fetch
   typedef struct packed {
      logic                  addr_ok;
      logic                  valid;
      logic [`IFU_GRLEN-1:0] rdata;
   } fetch_rsp_t;

   // fetch to decode
   typedef struct packed {
      logic        valid;
      pc_t         pc;
      logic [31:0] inst;
   } dec_out_t;

   // pcs of the later stages
   typedef struct packed {
      logic valid_e;
      pc_t  pc_e;
      pc_t  pc_w;
   } pc_pipe_t;

endpackage

/* rtl/ifu_pc_sel.sv */
`timescale 1ns/1ps
`include "ifu_config.svh"

module ifu_pc_sel (
   input  logic               clk,
   input  logic               arst_n,
   input  ifu_pkg::pc_t       pc_init,
   input  ifu_pkg::redirect_t redir,
   input  logic               fetch_valid,
   input  logic               stall,
   output ifu_pkg::pc_t       pc_f,
   output ifu_pkg::pc_t       pc_bf
);
   import ifu_pkg::*;

   logic run;
   logic sel_init;
   logic sel_hold;
   pc_t  pc_inc;

   // goes high on the first edge after arst_n releases
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run <= 1'b0;
      end else begin
         run <= 1'b1;
      end
   end

   // boot pc until out of reset
   assign sel_init = ~run;

   // nothing returned yet or execute is busy
   assign sel_hold = ~fetch_valid | stall;

   // next sequential word
   // byte offset bits pass through
   assign pc_inc = {pc_f[`IFU_GRLEN-1:2] + 1'b1, pc_f[1:0]};

   // ======================================================================
   // next pc priority mux
   // ======================================================================

   // exception wins over stall
   // ertn and branch also override hold
   always_comb begin
      if (sel_init) begin
         pc_bf = pc_init;
      end else if (redir.except) begin
         pc_bf = redir.eentry;
      end else if (redir.ertn) begin
         pc_bf = redir.era;
      end else if (redir.br_taken) begin
         pc_bf = redir.br_target;
      end else if (sel_hold) begin
         pc_bf = pc_f;
      end else begin
         pc_bf = pc_inc;
      end
   end

   // fetch stage pc
   // loads pc_init on the clocks seen during reset
   always_ff @(posedge clk) begin
      pc_f <= pc_bf;
   end

endmodule

/* rtl/ifu_fetch_req.sv */
`timescale 1ns/1ps

module ifu_fetch_req (
   input  logic clk,
   input  logic arst_n,
   input  logic stall,
   input  logic fetch_valid,
   output logic req
);

   logic run;
   logic req_bgn;
   logic req_end;
   logic req_in;
   logic req_q;

   // out of reset flag
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run <= 1'b0;
      end else begin
         run <= 1'b1;
      end
   end

   // new fetch only when execute can take it
   assign req_bgn = run & ~stall;

   // answer closes the fetch
   assign req_end = fetch_valid;

   // held while outstanding
   // dropped for the cycle of the answer
   assign req_in = (req_q | req_bgn) & ~req_end;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_q <= 1'b0;
      end else begin
         req_q <= req_in;
      end
   end

   // sole driver of the memory request
   assign req = req_in;

endmodule

/* rtl/ifu_pc_pipe.sv */
`timescale 1ns/1ps

module ifu_pc_pipe (
   input  logic              clk,
   input  logic              arst_n,
   input  ifu_pkg::pc_t      pc_f,
   input  logic [31:0]       inst_f,
   input  logic              fetch_valid,
   input  logic              kill_f,
   input  logic              kill_d,
   input  logic              stall,
   output ifu_pkg::dec_out_t dec,
   output ifu_pkg::pc_pipe_t pipe
);
   import ifu_pkg::*;

   logic        valid_f_live;
   logic        valid_d;
   logic        valid_d_live;
   logic        valid_e;
   logic        pc_d_en;
   logic        pc_e_en;
   pc_t         pc_d;
   pc_t         pc_e;
   pc_t         pc_m;
   pc_t         pc_w;
   logic [31:0] inst_d;

   // fetch answer not on a killed path
   assign valid_f_live = fetch_valid & ~kill_f;

   // decode slot after branch or exception kill
   assign valid_d_live = valid_d & ~kill_d;

   // ======================================================================
   // valid and kill chain
   // ======================================================================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_d <= 1'b0;
         valid_e <= 1'b0;
      end else if (stall) begin
         // stages frozen
         // a kill still empties the decode slot
         valid_d <= valid_d_live;
      end else begin
         valid_d <= valid_f_live;
         valid_e <= valid_d_live;
      end
   end

   // ======================================================================
   // pc and instruction registers
   // ======================================================================

   assign pc_d_en = valid_f_live & ~stall;
   assign pc_e_en = valid_d_live & ~stall;

   // fetch to decode
   always_ff @(posedge clk) begin
      if (pc_d_en) begin
         pc_d   <= pc_f;
         inst_d <= inst_f;
      end
   end

   // decode to execute
   always_ff @(posedge clk) begin
      if (pc_e_en) begin
         pc_e <= pc_d;
      end
   end

   // memory and writeback run every cycle
   // writeback pc feeds the debug port
   always_ff @(posedge clk) begin
      pc_m <= pc_e;
      pc_w <= pc_m;
   end

   assign dec.valid    = valid_d_live;
   assign dec.pc       = pc_d;
   assign dec.inst     = inst_d;

   assign pipe.valid_e = valid_e;
   assign pipe.pc_e    = pc_e;
   assign pipe.pc_w    = pc_w;

endmodule

/* rtl/ifu_fdp.sv */
`timescale 1ns/1ps

module ifu_fdp (
   input  logic                clk,
   input  logic                arst_n,
   input  ifu_pkg::pc_t        pc_init,
   output ifu_pkg::fetch_req_t freq,
   input  ifu_pkg::fetch_rsp_t frsp,
   input  ifu_pkg::redirect_t  redir,
   input  logic                stall,
   output ifu_pkg::dec_out_t   dec,
   output ifu_pkg::pc_pipe_t   pipe
);
   import ifu_pkg::*;

   logic        fetch_valid;
   logic        kill_f;
   logic        kill_d;
   pc_t         pc_f;
   pc_t         pc_bf;
   logic [31:0] inst_f;

   assign fetch_valid = frsp.valid;

   // low word holds the instruction
   assign inst_f = frsp.rdata[31:0];

   // any redirect drops the fetch stage item
   assign kill_f = redir.br_taken | redir.except | redir.ertn;

   // ertn leaves the decode item alone
   assign kill_d = redir.br_taken | redir.except;

   // ======================================================================
   // next pc, request and pipeline
   // ======================================================================

   ifu_pc_sel u_pc_sel (
      .clk         (clk),
      .arst_n      (arst_n),
      .pc_init     (pc_init),
      .redir       (redir),
      .fetch_valid (fetch_valid),
      .stall       (stall),
      .pc_f        (pc_f),
      .pc_bf       (pc_bf)
   );

   ifu_fetch_req u_fetch_req (
      .clk         (clk),
      .arst_n      (arst_n),
      .stall       (stall),
      .fetch_valid (fetch_valid),
      .req         (freq.req)
   );

   ifu_pc_pipe u_pc_pipe (
      .clk         (clk),
      .arst_n      (arst_n),
      .pc_f        (pc_f),
      .inst_f      (inst_f),
      .fetch_valid (fetch_valid),
      .kill_f      (kill_f),
      .kill_d      (kill_d),
      .stall       (stall),
      .dec         (dec),
      .pipe        (pipe)
   );

   // memory sees the next pc in the same cycle
   assign freq.addr   = pc_bf;

   // pending answer is dropped on any redirect
   assign freq.cancel = kill_f;

endmodule

/* rtl/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top (
   input  logic                clk,
   input  logic                arst_n,
   input  ifu_pkg::pc_t        pc_init,
   output ifu_pkg::fetch_req_t freq,
   input  ifu_pkg::fetch_rsp_t frsp,
   input  ifu_pkg::redirect_t  redir,
   input  logic                stall,
   output ifu_pkg::dec_out_t   dec,
   output ifu_pkg::pc_pipe_t   pipe
);

   // ======================================================================
   // fetch datapath
   // ======================================================================

   // memory port, redirect and decode port all as structs
   ifu_fdp u_fdp (
      .clk     (clk),
      .arst_n  (arst_n),
      .pc_init (pc_init),
      .freq    (freq),
      .frsp    (frsp),
      .redir   (redir),
      .stall   (stall),
      .dec     (dec),
      .pipe    (pipe)
   );

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
   parameter logic [31:0] MEM_XOR = 32'h0
) (
   input  logic                clk,
   input  logic                arst_n,
   input  ifu_pkg::pc_t        pc_init,
   input  ifu_pkg::fetch_req_t freq,
   input  ifu_pkg::redirect_t  redir,
   input  logic                stall,
   input  ifu_pkg::dec_out_t   dec,
   input  ifu_pkg::pc_pipe_t   pipe,
   output int                  err_count,
   output int                  item_count
);
   import ifu_pkg::*;

   int       errs = 0;
   int       items = 0;
   int       hist = 0;
   logic     first_req = 1'b0;
   logic     first_item = 1'b0;
   logic     prv_stall = 1'b0;
   logic     kill_d;
   logic     new_item;
   dec_out_t prv_dec = '0;
   pc_t      prv_pc_e = '0;
   pc_t      prv2_pc_e = '0;
   logic     prv_valid_e = 1'b0;
   pc_t      exp_pc = '0;

   assign err_count  = errs;
   assign item_count = items;

   // memory contents as a function of the address
   function automatic logic [31:0] mem_pattern(input pc_t a);
      return {a[22:0], a[31:23]} ^ MEM_XOR;
   endfunction

   // exception, then exception return, then branch, then sequential
   function automatic pc_t next_dec_pc(input pc_t seq_pc, input redirect_t r);
      return r.except   ? r.eentry :
             r.ertn     ? r.era :
             r.br_taken ? r.br_target :
             seq_pc;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         errs++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   // ======================================================================
   // per cycle comparison
   // ======================================================================

   always @(posedge clk) begin
      // branch or exception empties the decode slot
      kill_d   = redir.br_taken | redir.except;
      // decode item is fresh unless a stall held it
      new_item = dec.valid && !prv_stall;
      if (!arst_n) begin
         check_value("reset_req", 32'd0, 32'(freq.req));
         check_value("reset_cancel", 32'd0, 32'(freq.cancel));
         check_value("reset_dec_valid", 32'd0, 32'(dec.valid));
         check_value("reset_valid_e", 32'd0, 32'(pipe.valid_e));
         first_req  = 1'b0;
         first_item = 1'b0;
         hist       = 0;
         exp_pc     = pc_init;
      end else begin
         // boot fetch address
         if (!first_req && freq.req) begin
            first_req = 1'b1;
            check_value("first_addr", pc_init, freq.addr);
         end
         if (dec.valid) begin
            check_value("dec_inst", mem_pattern(dec.pc), dec.inst);
         end
         if (new_item) begin
            if (!first_item) begin
               check_value("first_dec_pc", pc_init, dec.pc);
            end
            first_item = 1'b1;
            items++;
            check_value("dec_pc_seq", exp_pc, dec.pc);
            // resync after a mismatch too
            exp_pc = dec.pc + 32'd4;
         end
         exp_pc = next_dec_pc(exp_pc, redir);
         if (redir.br_taken || redir.except || redir.ertn) begin
            check_value("cancel_on_redirect", 32'd1, 32'(freq.cancel));
            // new target on the fetch port in the pulse cycle
            if (freq.req) begin
               check_value("redirect_addr", next_dec_pc(32'd0, redir), freq.addr);
            end
         end
         if (kill_d) begin
            check_value("dec_kill", 32'd0, 32'(dec.valid));
         end
         // frozen decode and execute under stall
         if (hist >= 1 && prv_stall) begin
            check_value("stall_dec_pc", prv_dec.pc, dec.pc);
            check_value("stall_pc_e", prv_pc_e, pipe.pc_e);
            check_value("stall_valid_e", 32'(prv_valid_e), 32'(pipe.valid_e));
            if (!kill_d) begin
               check_value("stall_dec_valid", 32'(prv_dec.valid), 32'(dec.valid));
            end
         end
         if (hist >= 1 && !prv_stall) begin
            check_value("valid_e_follow", 32'(prv_dec.valid), 32'(pipe.valid_e));
         end
         if (hist >= 2) begin
            check_value("pc_w_delay", prv2_pc_e, pipe.pc_w);
         end
         hist++;
      end
      prv2_pc_e   = prv_pc_e;
      prv_pc_e    = pipe.pc_e;
      prv_valid_e = pipe.valid_e;
      prv_dec     = dec;
      prv_stall   = stall;
   end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`include "ifu_config.svh"

module tb_top;
   import ifu_pkg::*;

   localparam logic [31:0] SEED        = 32'hc2a0;
   localparam logic [31:0] MEM_XOR     = 32'h5a3c_96e1;
   localparam int          ITEMS_GOAL  = 400;
   localparam int          FIRST_LIMIT = 64;
   localparam int          RUN_LIMIT   = 20000;
   localparam int          DRAIN_LIMIT = 200;

   logic        clk;
   logic        arst_n;
   pc_t         pc_init;
   fetch_req_t  freq;
   fetch_rsp_t  frsp = '0;
   redirect_t   redir;
   logic        stall;
   dec_out_t    dec;
   pc_pipe_t    pipe;
   int          err_count;
   int          item_count;
   int          timeouts;
   int          stall_left;
   logic [31:0] stim_rng = SEED;
   logic [31:0] mem_rng = SEED ^ 32'h9e37_79b9;
   // memory model state
   logic        pending = 1'b0;
   logic        ans_next = 1'b0;
   logic        acc_next = 1'b0;
   pc_t         pend_addr = '0;
   int          wait_cnt = 0;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // address rotated left by 9, then scrambled
   function automatic logic [31:0] mem_word(input pc_t a);
      return {a[22:0], a[31:23]} ^ MEM_XOR;
   endfunction

   initial clk = 1'b0;
   always #2 clk = ~clk;

   ifu_top dut (.*);

   tb_checker #(.MEM_XOR(MEM_XOR)) u_checker (.*);

   // ======================================================================
   // instruction memory model
   // ======================================================================

   // cancel and accept seen on the rising edge
   always @(posedge clk) begin
      acc_next = 1'b0;
      if (!arst_n) begin
         pending = 1'b0;
      end else begin
         // answer delivered or fetch abandoned
         if (frsp.valid || freq.cancel) begin
            pending = 1'b0;
         end
         if (freq.req && !pending) begin
            mem_rng   = xorshift32(mem_rng);
            pending   = 1'b1;
            acc_next  = 1'b1;
            pend_addr = freq.addr;
            wait_cnt  = 1 + int'(mem_rng % 32'd3);
         end
      end
      // answer 1 to 3 cycles after accept
      ans_next = pending && (wait_cnt == 1);
      if (pending) begin
         wait_cnt = wait_cnt - 1;
      end
   end

   always @(negedge clk) begin
      frsp.addr_ok = acc_next;
      frsp.valid   = ans_next;
      frsp.rdata   = ans_next ? mem_word(pend_addr) : 32'h0;
   end

   // ======================================================================
   // redirect and stall stimulus
   // ======================================================================

   // random stall bursts, redirect pulses, word aligned targets
   task automatic drive_traffic();
      logic [31:0] r;
      stim_rng = xorshift32(stim_rng);
      r = stim_rng;
      if (stall_left == 0 && r[3:0] == 4'h0) begin
         stall_left = 1 + int'(r[6:4]);
      end
      stall = (stall_left != 0);
      if (stall_left != 0) begin
         stall_left = stall_left - 1;
      end
      redir = '0;
      // targets change every cycle, ignored without a pulse
      stim_rng = xorshift32(stim_rng);
      redir.eentry = {stim_rng[31:2], 2'b00};
      stim_rng = xorshift32(stim_rng);
      redir.era = {stim_rng[31:2], 2'b00};
      stim_rng = xorshift32(stim_rng);
      redir.br_target = {stim_rng[31:2], 2'b00};
      // several fields at once exercise the priority
      if (r[12:8] < 5'd3) begin
         redir.except   = r[15];
         redir.ertn     = r[14];
         redir.br_taken = r[13] | (r[15:13] == 3'b000);
      end
   endtask

   task automatic drive_quiet();
      redir = '0;
      stall = 1'b0;
   endtask

   // run until the decode count reaches goal, bounded in cycles
   task automatic wait_items(input int goal, input int limit, input bit busy,
                             input string what);
      int n;
      n = 0;
      while (item_count < goal && n < limit) begin
         @(negedge clk);
         if (busy) begin
            drive_traffic();
         end else begin
            drive_quiet();
         end
         n++;
      end
      if (item_count < goal) begin
         timeouts++;
         $display("timeout in %s: only %0d of %0d decode items after %0d cycles",
                  what, item_count, goal, limit);
      end
   endtask

   initial begin
      // reset edge lands after time zero
      arst_n     = 1'b1;
      pc_init    = `IFU_PC_RESET;
      stall      = 1'b0;
      redir      = '0;
      stall_left = 0;
      timeouts   = 0;
      @(negedge clk);
      arst_n = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      // quiet start so the boot fetch comes from pc_init
      wait_items(1, FIRST_LIMIT, 1'b0, "first decode after reset");
      if (timeouts == 0) begin
         wait_items(ITEMS_GOAL, RUN_LIMIT, 1'b1, "random redirect and stall traffic");
      end
      if (timeouts == 0) begin
         // pipeline refills once traffic stops
         wait_items(item_count + 8, DRAIN_LIMIT, 1'b0, "drain after traffic");
      end
      $display("closing: %0d decode items, %0d mismatches, %0d timeouts",
               item_count, err_count, timeouts);
      if (err_count == 0 && timeouts == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+rtl
rtl/ifu_pkg.sv
rtl/ifu_pc_sel.sv
rtl/ifu_fetch_req.sv
rtl/ifu_pc_pipe.sv
rtl/ifu_fdp.sv
rtl/ifu_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then decide on the pass line in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
